// File: src/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // register file word width
    localparam int unsigned XLEN = 32;

    // x0..x31 index width
    localparam int unsigned REG_ADDR_W = 5;

    // one data word as held in the register file
    typedef logic [XLEN-1:0] word_t;

    // one register index
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // return address offset written by jal and jalr
    localparam word_t PC_STEP = word_t'(4);

    // decoded instruction kind from the decode stage
    // system, fence and csr instructions arrive as INST_UNKNOWN
    typedef enum logic [5:0] {
        INST_UNKNOWN,
        // register-register arithmetic
        INST_ADD, INST_SUB, INST_XOR, INST_OR, INST_AND,
        INST_SLL, INST_SRL, INST_SRA, INST_SLT, INST_SLTU,
        // register-immediate arithmetic
        INST_ADDI, INST_XORI, INST_ORI, INST_ANDI,
        INST_SLLI, INST_SRLI, INST_SRAI, INST_SLTI, INST_SLTIU,
        // loads, the stage only forms the address
        INST_LB, INST_LH, INST_LW, INST_LBU, INST_LHU,
        // stores, address only and no register write
        INST_SB, INST_SH, INST_SW,
        // conditional branches
        INST_BEQ, INST_BNE, INST_BLT, INST_BGE, INST_BLTU, INST_BGEU,
        // jumps
        INST_JAL, INST_JALR,
        // upper immediates
        INST_LUI, INST_AUIPC
    } inst_e;

endpackage

`default_nettype wire

// File: src/exec_pkg.sv
`default_nettype none

package exec_pkg;

    // shift amount taken from the low bits of operand b
    localparam int unsigned SHAMT_W = 5;

    // alu operation
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        // signed compare, result is 0 or 1
        ALU_SLT,
        // unsigned compare, result is 0 or 1
        ALU_SLTU,
        // operand b straight through, used by lui
        ALU_PASS_B
    } alu_op_e;

    // operand a source
    typedef enum logic [1:0] {
        OPA_RS1,
        OPA_PC,
        OPA_ZERO
    } opa_sel_e;

    // operand b source
    typedef enum logic [1:0] {
        OPB_RS2,
        OPB_IMM,
        // constant link offset for jal and jalr
        OPB_STEP
    } opb_sel_e;

    // branch condition between rs1 and rs2
    typedef enum logic [2:0] {
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } br_cond_e;

endpackage

`default_nettype wire

// File: src/exec_decode.sv
`default_nettype none
`timescale 1ns/10ps

module exec_decode
    import rv_isa_pkg::*;
    import exec_pkg::*;
(
    input  wire inst_e    inst_i,
    output alu_op_e       alu_op_o,
    output opa_sel_e      opa_sel_o,
    output opb_sel_e      opb_sel_o,
    output logic          is_branch_o,
    output br_cond_e      br_cond_o,
    output logic          is_jump_o,
    output logic          target_from_rs1_o,
    output logic          wr_en_o
);

    // alu operation shared by the register and immediate forms
    function automatic alu_op_e alu_op_of(input inst_e inst);
        case (inst)
            INST_SUB:               return ALU_SUB;
            INST_XOR, INST_XORI:    return ALU_XOR;
            INST_OR, INST_ORI:      return ALU_OR;
            INST_AND, INST_ANDI:    return ALU_AND;
            INST_SLL, INST_SLLI:    return ALU_SLL;
            INST_SRL, INST_SRLI:    return ALU_SRL;
            INST_SRA, INST_SRAI:    return ALU_SRA;
            INST_SLT, INST_SLTI:    return ALU_SLT;
            INST_SLTU, INST_SLTIU:  return ALU_SLTU;
            // add and addi
            default:                return ALU_ADD;
        endcase
    endfunction

    always_comb begin
        // safe values: zero result, no write, no redirect
        // 0 & rs2 keeps the result at zero for unknown kinds
        alu_op_o          = ALU_AND;
        opa_sel_o         = OPA_ZERO;
        opb_sel_o         = OPB_RS2;
        is_branch_o       = 1'b0;
        br_cond_o         = BR_EQ;
        is_jump_o         = 1'b0;
        target_from_rs1_o = 1'b0;
        wr_en_o           = 1'b0;

        case (inst_i)
            INST_ADD, INST_SUB, INST_XOR, INST_OR, INST_AND,
            INST_SLL, INST_SRL, INST_SRA, INST_SLT, INST_SLTU: begin
                // rs1 op rs2
                alu_op_o  = alu_op_of(inst_i);
                opa_sel_o = OPA_RS1;
                wr_en_o   = 1'b1;
            end
            INST_ADDI, INST_XORI, INST_ORI, INST_ANDI,
            INST_SLLI, INST_SRLI, INST_SRAI, INST_SLTI, INST_SLTIU: begin
                // rs1 op imm, shifts take imm[4:0] in the alu
                alu_op_o  = alu_op_of(inst_i);
                opa_sel_o = OPA_RS1;
                opb_sel_o = OPB_IMM;
                wr_en_o   = 1'b1;
            end
            INST_LB, INST_LH, INST_LW, INST_LBU, INST_LHU: begin
                // effective address, the loaded value lands in rd later
                alu_op_o  = ALU_ADD;
                opa_sel_o = OPA_RS1;
                opb_sel_o = OPB_IMM;
                wr_en_o   = 1'b1;
            end
            INST_SB, INST_SH, INST_SW: begin
                // effective address only
                alu_op_o  = ALU_ADD;
                opa_sel_o = OPA_RS1;
                opb_sel_o = OPB_IMM;
            end
            // branches compare rs1 with rs2 in the branch unit
            INST_BEQ: begin
                is_branch_o = 1'b1;
                br_cond_o   = BR_EQ;
            end
            INST_BNE: begin
                is_branch_o = 1'b1;
                br_cond_o   = BR_NE;
            end
            INST_BLT: begin
                is_branch_o = 1'b1;
                br_cond_o   = BR_LT;
            end
            INST_BGE: begin
                is_branch_o = 1'b1;
                br_cond_o   = BR_GE;
            end
            INST_BLTU: begin
                is_branch_o = 1'b1;
                br_cond_o   = BR_LTU;
            end
            INST_BGEU: begin
                is_branch_o = 1'b1;
                br_cond_o   = BR_GEU;
            end
            INST_JAL, INST_JALR: begin
                // rd gets the return address pc + 4
                alu_op_o          = ALU_ADD;
                opa_sel_o         = OPA_PC;
                opb_sel_o         = OPB_STEP;
                is_jump_o         = 1'b1;
                target_from_rs1_o = (inst_i == INST_JALR);
                wr_en_o           = 1'b1;
            end
            INST_LUI: begin
                alu_op_o  = ALU_PASS_B;
                opb_sel_o = OPB_IMM;
                wr_en_o   = 1'b1;
            end
            INST_AUIPC: begin
                alu_op_o  = ALU_ADD;
                opa_sel_o = OPA_PC;
                opb_sel_o = OPB_IMM;
                wr_en_o   = 1'b1;
            end
            // unknown kinds keep the safe values
            default: begin
            end
        endcase
    end

    // the branch unit and retire register assume at most one redirect kind
    always_comb begin
        assert (!(is_branch_o && is_jump_o))
            else $error("exec_decode: branch and jump both set for %s", inst_i.name());
    end

endmodule

`default_nettype wire

// File: src/exec_alu.sv
`default_nettype none
`timescale 1ns/10ps

module exec_alu
    import rv_isa_pkg::*;
    import exec_pkg::*;
(
    input  wire word_t    rs1_data_i,
    input  wire word_t    rs2_data_i,
    input  wire word_t    imm_i,
    input  wire word_t    pc_i,
    input  wire alu_op_e  alu_op_i,
    input  wire opa_sel_e opa_sel_i,
    input  wire opb_sel_e opb_sel_i,
    output word_t         result_o
);

    word_t              op_a;
    word_t              op_b;
    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    // operand a mux
    always_comb begin
        case (opa_sel_i)
            OPA_RS1: op_a = rs1_data_i;
            OPA_PC:  op_a = pc_i;
            OPA_ZERO: op_a = '0;
            default: op_a = '0;
        endcase
    end

    // operand b mux
    always_comb begin
        case (opb_sel_i)
            OPB_RS2:  op_b = rs2_data_i;
            OPB_IMM:  op_b = imm_i;
            OPB_STEP: op_b = PC_STEP;
            default:  op_b = rs2_data_i;
        endcase
    end

    // rv32i shifts only look at the low five bits
    assign shamt = op_b[SHAMT_W-1:0];

    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    always_comb begin
        case (alu_op_i)
            ALU_ADD:    result_o = op_a + op_b;
            ALU_SUB:    result_o = op_a - op_b;
            ALU_XOR:    result_o = op_a ^ op_b;
            ALU_OR:     result_o = op_a | op_b;
            ALU_AND:    result_o = op_a & op_b;
            ALU_SLL:    result_o = op_a << shamt;
            ALU_SRL:    result_o = op_a >> shamt;
            // sign bit fills from the left
            ALU_SRA:    result_o = word_t'($signed(op_a) >>> shamt);
            ALU_SLT:    result_o = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:   result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_PASS_B: result_o = op_b;
            default:    result_o = '0;
        endcase
    end

    // the decode only ever produces the listed mux codes
    always_comb begin
        assert (opa_sel_i inside {OPA_RS1, OPA_PC, OPA_ZERO}
                && opb_sel_i inside {OPB_RS2, OPB_IMM, OPB_STEP})
            else $error("exec_alu: illegal operand select a=%0d b=%0d", opa_sel_i, opb_sel_i);
    end

endmodule

`default_nettype wire

// File: src/exec_branch.sv
`default_nettype none
`timescale 1ns/10ps

module exec_branch
    import rv_isa_pkg::*;
    import exec_pkg::*;
(
    input  wire word_t    rs1_data_i,
    input  wire word_t    rs2_data_i,
    input  wire word_t    imm_i,
    input  wire word_t    pc_i,
    input  wire           is_branch_i,
    input  wire br_cond_e br_cond_i,
    input  wire           is_jump_i,
    input  wire           target_from_rs1_i,
    output word_t         target_o,
    output logic          taken_o,
    output logic          jump_o
);

    logic  eq;
    logic  lt_signed;
    logic  lt_unsigned;
    logic  cond;
    word_t base;
    word_t sum;

    // comparator shared by all six conditions
    assign eq          = rs1_data_i == rs2_data_i;
    assign lt_signed   = $signed(rs1_data_i) < $signed(rs2_data_i);
    assign lt_unsigned = rs1_data_i < rs2_data_i;

    always_comb begin
        case (br_cond_i)
            BR_EQ:   cond = eq;
            BR_NE:   cond = !eq;
            BR_LT:   cond = lt_signed;
            BR_GE:   cond = !lt_signed;
            BR_LTU:  cond = lt_unsigned;
            BR_GEU:  cond = !lt_unsigned;
            default: cond = 1'b0;
        endcase
    end

    assign taken_o = is_branch_i && cond;
    assign jump_o  = is_jump_i;

    // jalr is register relative, everything else pc relative
    assign base = target_from_rs1_i ? rs1_data_i : pc_i;
    assign sum  = base + imm_i;

    always_comb begin
        if (is_branch_i || is_jump_i) begin
            // jalr drops bit 0 of the computed address
            target_o = {sum[XLEN-1:1], sum[0] & ~target_from_rs1_i};
        end else begin
            target_o = '0;
        end
    end

endmodule

`default_nettype wire

// File: src/exec_retire_reg.sv
`default_nettype none
`timescale 1ns/10ps

module exec_retire_reg
    import rv_isa_pkg::*;
(
    input  wire            i_clk,
    input  wire            arst_n_i,
    input  wire            valid_i,
    input  wire word_t     result_i,
    input  wire word_t     target_i,
    input  wire            taken_i,
    input  wire            jump_i,
    input  wire            wr_en_i,
    input  wire reg_addr_t rd_i,
    output logic           valid_o,
    output word_t          result_o,
    output word_t          target_o,
    output logic           branch_taken_o,
    output logic           jump_o,
    output logic           wr_en_o,
    output reg_addr_t      rd_o
);

    logic rd_nonzero;

    // writes to x0 are dropped here
    assign rd_nonzero = rd_i != '0;

    // control bits, only set for a valid instruction
    always_ff @(posedge i_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o        <= 1'b0;
            branch_taken_o <= 1'b0;
            jump_o         <= 1'b0;
            wr_en_o        <= 1'b0;
        end else begin
            valid_o        <= valid_i;
            branch_taken_o <= valid_i && taken_i;
            jump_o         <= valid_i && jump_i;
            wr_en_o        <= valid_i && wr_en_i && rd_nonzero;
        end
    end

    // payload, qualified by valid_o downstream
    always_ff @(posedge i_clk) begin
        result_o <= result_i;
        target_o <= target_i;
        rd_o     <= rd_i;
    end

    // never a register write to x0
    a_no_x0_write: assert property (
        @(posedge i_clk) disable iff (!arst_n_i)
        wr_en_o |-> (rd_o != '0)
    ) else $error("exec_retire_reg: write enable with rd x0");

endmodule

`default_nettype wire

// File: src/exec_stage.sv
`default_nettype none
`timescale 1ns/10ps

module exec_stage
    import rv_isa_pkg::*;
    import exec_pkg::*;
(
    input  wire            i_clk,
    input  wire            arst_n_i,
    input  wire            valid_i,
    input  wire inst_e     inst_i,
    input  wire reg_addr_t rd_i,
    input  wire word_t     rs1_data_i,
    input  wire word_t     rs2_data_i,
    input  wire word_t     imm_i,
    input  wire word_t     pc_i,
    output logic           valid_o,
    output word_t          result_o,
    output word_t          target_o,
    output logic           branch_taken_o,
    output logic           jump_o,
    output logic           wr_en_o,
    output reg_addr_t      rd_o
);

    // decode to datapath control
    alu_op_e  alu_op;
    opa_sel_e opa_sel;
    opb_sel_e opb_sel;
    logic     is_branch;
    br_cond_e br_cond;
    logic     is_jump;
    logic     target_from_rs1;
    logic     wr_en;

    // combinational results into the stage register
    word_t    alu_result;
    word_t    target;
    logic     taken;
    logic     jump;

    exec_decode exec_decode_i (
        .inst_i            (inst_i),
        .alu_op_o          (alu_op),
        .opa_sel_o         (opa_sel),
        .opb_sel_o         (opb_sel),
        .is_branch_o       (is_branch),
        .br_cond_o         (br_cond),
        .is_jump_o         (is_jump),
        .target_from_rs1_o (target_from_rs1),
        .wr_en_o           (wr_en)
    );

    exec_alu exec_alu_i (
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .imm_i      (imm_i),
        .pc_i       (pc_i),
        .alu_op_i   (alu_op),
        .opa_sel_i  (opa_sel),
        .opb_sel_i  (opb_sel),
        .result_o   (alu_result)
    );

    exec_branch exec_branch_i (
        .rs1_data_i        (rs1_data_i),
        .rs2_data_i        (rs2_data_i),
        .imm_i             (imm_i),
        .pc_i              (pc_i),
        .is_branch_i       (is_branch),
        .br_cond_i         (br_cond),
        .is_jump_i         (is_jump),
        .target_from_rs1_i (target_from_rs1),
        .target_o          (target),
        .taken_o           (taken),
        .jump_o            (jump)
    );

    // single pipeline register, one cycle latency
    exec_retire_reg exec_retire_reg_i (
        .i_clk          (i_clk),
        .arst_n_i       (arst_n_i),
        .valid_i        (valid_i),
        .result_i       (alu_result),
        .target_i       (target),
        .taken_i        (taken),
        .jump_i         (jump),
        .wr_en_i        (wr_en),
        .rd_i           (rd_i),
        .valid_o        (valid_o),
        .result_o       (result_o),
        .target_o       (target_o),
        .branch_taken_o (branch_taken_o),
        .jump_o         (jump_o),
        .wr_en_o        (wr_en_o),
        .rd_o           (rd_o)
    );

endmodule

`default_nettype wire

// File: sim/exec_tb_model.svh
`ifndef EXEC_TB_MODEL_SVH
`define EXEC_TB_MODEL_SVH

// one step of the 32 bit xorshift generator
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

function automatic logic is_branch_kind(input inst_e inst);
    return inst inside {[INST_BEQ:INST_BGEU]};
endfunction

function automatic logic is_jump_kind(input inst_e inst);
    return inst inside {INST_JAL, INST_JALR};
endfunction

// kinds that write rd in rv32i, stores and branches do not
function automatic logic writes_rd(input inst_e inst);
    return inst inside {[INST_ADD:INST_LHU], INST_JAL, INST_JALR, INST_LUI, INST_AUIPC};
endfunction

// value written back, or the address for loads and stores
function automatic word_t result_of(input inst_e inst, input word_t rs1, input word_t rs2,
                                    input word_t imm, input word_t pc);
    word_t              b;
    logic [SHAMT_W-1:0] sh;
    // immediate forms use imm where the register forms use rs2
    b  = (inst inside {[INST_ADDI:INST_SLTIU]}) ? imm : rs2;
    sh = b[SHAMT_W-1:0];
    case (inst)
        INST_ADD, INST_ADDI:   return rs1 + b;
        INST_SUB:              return rs1 - b;
        INST_XOR, INST_XORI:   return rs1 ^ b;
        INST_OR, INST_ORI:     return rs1 | b;
        INST_AND, INST_ANDI:   return rs1 & b;
        INST_SLL, INST_SLLI:   return rs1 << sh;
        INST_SRL, INST_SRLI:   return rs1 >> sh;
        INST_SRA, INST_SRAI:   return word_t'($signed(rs1) >>> sh);
        INST_SLT, INST_SLTI:   return ($signed(rs1) < $signed(b)) ? word_t'(1) : word_t'(0);
        INST_SLTU, INST_SLTIU: return (rs1 < b) ? word_t'(1) : word_t'(0);
        INST_LB, INST_LH, INST_LW, INST_LBU, INST_LHU,
        INST_SB, INST_SH, INST_SW: return rs1 + imm;
        // link address
        INST_JAL, INST_JALR:   return pc + word_t'(4);
        INST_LUI:              return imm;
        INST_AUIPC:            return pc + imm;
        default:               return '0;
    endcase
endfunction

// rv32i branch conditions, signed or unsigned by kind
function automatic logic branch_holds(input inst_e inst, input word_t rs1, input word_t rs2);
    case (inst)
        INST_BEQ:  return rs1 == rs2;
        INST_BNE:  return rs1 != rs2;
        INST_BLT:  return $signed(rs1) < $signed(rs2);
        INST_BGE:  return $signed(rs1) >= $signed(rs2);
        INST_BLTU: return rs1 < rs2;
        INST_BGEU: return rs1 >= rs2;
        default:   return 1'b0;
    endcase
endfunction

function automatic word_t target_of(input inst_e inst, input word_t rs1, input word_t imm,
                                    input word_t pc);
    // jalr clears bit 0 of rs1 + imm
    if (inst == INST_JALR) begin
        return (rs1 + imm) & ~word_t'(1);
    end
    // zero when there is no redirect at all
    return (is_branch_kind(inst) || inst == INST_JAL) ? pc + imm : '0;
endfunction

`endif

// File: sim/exec_tb.sv
`default_nettype none
`timescale 1ns/10ps

module exec_tb
    import rv_isa_pkg::*;
    import exec_pkg::*;
();

    `include "exec_tb_model.svh"

    localparam int DRAIN_LIMIT = 16;

    logic      i_clk;
    logic      arst_n_i;
    logic      valid_i;
    inst_e     inst_i;
    reg_addr_t rd_i;
    word_t     rs1_data_i;
    word_t     rs2_data_i;
    word_t     imm_i;
    word_t     pc_i;
    logic      valid_o;
    word_t     result_o;
    word_t     target_o;
    logic      branch_taken_o;
    logic      jump_o;
    logic      wr_en_o;
    reg_addr_t rd_o;

    // inputs the stage took on the last rising edge
    logic      prev_valid = 1'b0;
    inst_e     prev_inst = INST_UNKNOWN;
    reg_addr_t prev_rd = '0;
    word_t     prev_rs1 = '0;
    word_t     prev_rs2 = '0;
    word_t     prev_imm = '0;
    word_t     prev_pc = '0;

    // model outputs for that instruction
    word_t exp_result;
    word_t exp_target;
    logic  exp_taken;
    logic  exp_jump;
    logic  exp_wr_en;
    logic  exp_has_result;

    int          err_cnt = 0;
    int          test_cnt = 0;
    int          checked_cnt = 0;
    int          cycle_cnt = 0;
    logic [31:0] rng_state = 32'hd6af;

    exec_stage exec_stage_i (.*);

    always #50 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_cnt  <= cycle_cnt + 1;
        prev_valid <= valid_i;
        prev_inst  <= inst_i;
        prev_rd    <= rd_i;
        prev_rs1   <= rs1_data_i;
        prev_rs2   <= rs2_data_i;
        prev_imm   <= imm_i;
        prev_pc    <= pc_i;
        if (arst_n_i && prev_valid) begin
            checked_cnt <= checked_cnt + 1;
        end
    end

    always_comb begin
        exp_result     = result_of(prev_inst, prev_rs1, prev_rs2, prev_imm, prev_pc);
        exp_target     = target_of(prev_inst, prev_rs1, prev_imm, prev_pc);
        exp_taken      = branch_holds(prev_inst, prev_rs1, prev_rs2);
        exp_jump       = is_jump_kind(prev_inst);
        exp_wr_en      = writes_rd(prev_inst) && (prev_rd != '0);
        // branches have no architectural result
        exp_has_result = !is_branch_kind(prev_inst);
    end

    task automatic note_failure(input string msg);
        $display("FAILED at %0d ns: %s", $time, msg);
        err_cnt = err_cnt + 1;
    endtask

    // first edge skipped, the flops may not have seen reset yet
    a_reset_quiet: assert property (@(posedge i_clk)
        (!arst_n_i && cycle_cnt > 0) |-> !(valid_o || wr_en_o || branch_taken_o || jump_o)
    ) else note_failure("an output is high while reset is held");

    a_valid_delay: assert property (@(posedge i_clk) disable iff (!arst_n_i)
        valid_o == prev_valid
    ) else note_failure($sformatf("valid_o %b, expected %b", $sampled(valid_o),
                                  $sampled(prev_valid)));

    a_idle_quiet: assert property (@(posedge i_clk) disable iff (!arst_n_i)
        !prev_valid |-> !(wr_en_o || branch_taken_o || jump_o)
    ) else note_failure("control output high on an idle cycle");

    a_result: assert property (@(posedge i_clk) disable iff (!arst_n_i)
        (prev_valid && exp_has_result) |-> result_o == exp_result
    ) else note_failure($sformatf("result %h, expected %h, kind %0d", $sampled(result_o),
                                  $sampled(exp_result), $sampled(prev_inst)));

    a_target: assert property (@(posedge i_clk) disable iff (!arst_n_i)
        prev_valid |-> target_o == exp_target
    ) else note_failure($sformatf("target %h, expected %h, kind %0d", $sampled(target_o),
                                  $sampled(exp_target), $sampled(prev_inst)));

    a_taken: assert property (@(posedge i_clk) disable iff (!arst_n_i)
        prev_valid |-> branch_taken_o == exp_taken
    ) else note_failure($sformatf("branch_taken %b, expected %b, kind %0d",
                                  $sampled(branch_taken_o), $sampled(exp_taken),
                                  $sampled(prev_inst)));

    a_jump: assert property (@(posedge i_clk) disable iff (!arst_n_i)
        prev_valid |-> jump_o == exp_jump
    ) else note_failure($sformatf("jump %b, expected %b", $sampled(jump_o), $sampled(exp_jump)));

    a_wr_en: assert property (@(posedge i_clk) disable iff (!arst_n_i)
        prev_valid |-> wr_en_o == exp_wr_en
    ) else note_failure($sformatf("wr_en %b, expected %b, kind %0d, rd %0d", $sampled(wr_en_o),
                                  $sampled(exp_wr_en), $sampled(prev_inst), $sampled(prev_rd)));

    a_rd: assert property (@(posedge i_clk) disable iff (!arst_n_i)
        prev_valid |-> rd_o == prev_rd
    ) else note_failure($sformatf("rd %0d, expected %0d", $sampled(rd_o), $sampled(prev_rd)));

    function automatic word_t next_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // sign extended 12 bit immediate
    function automatic word_t rand_imm12();
        word_t r;
        r = next_word();
        return {{20{r[11]}}, r[11:0]};
    endfunction

    function automatic word_t rand_pc();
        word_t r;
        r = next_word();
        return {r[31:2], 2'b00};
    endfunction

    function automatic reg_addr_t rand_rd();
        return reg_addr_t'(next_word());
    endfunction

    // any of the 38 kinds, unknown included
    function automatic inst_e rand_kind();
        return inst_e'(6'(next_word() % 32'd38));
    endfunction

    task automatic apply(input inst_e inst, input reg_addr_t rd, input word_t rs1,
                         input word_t rs2, input word_t imm, input word_t pc);
        @(negedge i_clk);
        valid_i    = 1'b1;
        inst_i     = inst;
        rd_i       = rd;
        rs1_data_i = rs1;
        rs2_data_i = rs2;
        imm_i      = imm;
        pc_i       = pc;
    endtask

    // junk payload with valid low, nothing may leak to the controls
    task automatic idle_cycle();
        @(negedge i_clk);
        valid_i    = 1'b0;
        inst_i     = rand_kind();
        rd_i       = rand_rd();
        rs1_data_i = next_word();
        rs2_data_i = next_word();
        imm_i      = rand_imm12();
        pc_i       = rand_pc();
    endtask

    // go idle and wait for the last instruction to leave the stage
    task automatic finish_test(input string name);
        int waited;
        waited = 0;
        idle_cycle();
        do begin
            @(negedge i_clk);
            waited++;
        end while (valid_o && waited < DRAIN_LIMIT);
        if (valid_o) begin
            $display("timeout: valid_o still high %0d cycles after the last instruction", waited);
            $display("Finished with errors");
            $finish;
        end else begin
            test_cnt++;
            $display("test %0d %s done, %0d errors so far", test_cnt, name, err_cnt);
        end
    endtask

    initial begin
        int held;
        i_clk      = 1'b0;
        arst_n_i   = 1'b0;
        valid_i    = 1'b0;
        inst_i     = INST_UNKNOWN;
        rd_i       = '0;
        rs1_data_i = '0;
        rs2_data_i = '0;
        imm_i      = '0;
        pc_i       = '0;

        // eight rising edges in reset, released on a falling edge
        held = 0;
        while (held < 8) begin
            @(negedge i_clk);
            held++;
        end
        arst_n_i = 1'b1;
        finish_test("reset state");

        // every register and immediate kind with random operands
        for (int k = int'(INST_ADD); k <= int'(INST_SLTIU); k++) begin
            for (int n = 0; n < 6; n++) begin
                apply(inst_e'(k), rand_rd(), next_word(), next_word(), rand_imm12(),
                      rand_pc());
            end
        end
        apply(INST_SUB, 5'd1, 32'd3, 32'd5, '0, '0);
        // shift amount 36 keeps only 4, sign fills from the left
        apply(INST_SRA, 5'd2, 32'h8000_00f0, 32'd36, '0, '0);
        apply(INST_SRAI, 5'd3, 32'hf000_0000, '0, 32'h0000_0407, '0);
        // -1 against 1, signed and unsigned disagree
        apply(INST_SLT, 5'd4, 32'hffff_ffff, 32'd1, '0, '0);
        apply(INST_SLTU, 5'd5, 32'hffff_ffff, 32'd1, '0, '0);
        apply(INST_SLTI, 5'd6, 32'd0, 32'd9, 32'hffff_fff0, '0);
        apply(INST_SLTIU, 5'd7, 32'd0, 32'd9, 32'hffff_fff0, '0);
        // x0 as destination
        apply(INST_ADD, 5'd0, 32'd1, 32'd2, '0, '0);
        finish_test("register and immediate arithmetic");

        // equal, signed smaller and unsigned smaller pairs per condition
        for (int k = int'(INST_BEQ); k <= int'(INST_BGEU); k++) begin
            apply(inst_e'(k), rand_rd(), 32'h1234_5678, 32'h1234_5678, rand_imm12(), rand_pc());
            apply(inst_e'(k), rand_rd(), 32'hffff_fffb, 32'd3, rand_imm12(), rand_pc());
            apply(inst_e'(k), rand_rd(), 32'd3, 32'hffff_fffb, rand_imm12(), rand_pc());
            apply(inst_e'(k), rand_rd(), next_word(), next_word(), rand_imm12(), rand_pc());
        end
        finish_test("branches");

        for (int n = 0; n < 8; n++) begin
            apply(INST_JAL, rand_rd(), next_word(), next_word(), rand_imm12(), rand_pc());
            // odd sum so the cleared bit 0 is visible
            apply(INST_JALR, rand_rd(), next_word() | 32'd1, next_word(),
                  rand_imm12() & ~32'd1, rand_pc());
        end
        finish_test("jumps");

        for (int k = int'(INST_LB); k <= int'(INST_SW); k++) begin
            apply(inst_e'(k), rand_rd(), next_word(), next_word(), rand_imm12(), rand_pc());
        end
        apply(INST_LW, 5'd0, next_word(), next_word(), rand_imm12(), rand_pc());
        apply(INST_LUI, rand_rd(), next_word(), next_word(), next_word() & 32'hffff_f000,
              rand_pc());
        apply(INST_AUIPC, rand_rd(), next_word(), next_word(), next_word() & 32'hffff_f000,
              rand_pc());
        apply(INST_UNKNOWN, rand_rd() | 5'd1, next_word(), next_word(), rand_imm12(),
              rand_pc());
        finish_test("memory address, upper immediates and unknown");

        // back to back mix with an idle cycle about one time in eight
        for (int n = 0; n < 200; n++) begin
            if ((next_word() & 32'd7) == 32'd0) begin
                idle_cycle();
            end else begin
                apply(rand_kind(), rand_rd(), next_word(), next_word(), rand_imm12(),
                      rand_pc());
            end
        end
        finish_test("streaming");

        $display("tests %0d, instructions checked %0d, errors %0d", test_cnt, checked_cnt,
                 err_cnt);
        if (err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+sim
src/rv_isa_pkg.sv
src/exec_pkg.sv
src/exec_decode.sv
src/exec_alu.sv
src/exec_branch.sv
src/exec_retire_reg.sv
src/exec_stage.sv
sim/exec_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module exec_tb -Mdir obj_dir -f all.f

# the log decides pass or fail, not the exit code of the simulation
run: compile
	./obj_dir/Vexec_tb | tee $(LOG)
	grep -qx "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
